// ==== cache_apb_ctrl.sv ====
`timescale 1ns/1ps

module cache_apb_ctrl (
	input  logic                         CLK,
	input  logic                         arst_n,
	input  logic                         psel,
	input  logic                         penable,
	input  logic                         pwrite,
	input  logic [cache_pkg::ADDR_W-1:0] paddr,
	input  logic [cache_pkg::DATA_W-1:0] pwdata,
	input  logic [cache_pkg::STRB_W-1:0] pstrb,
	output logic                         pready,
	output logic                         resolve, // Read results are due this cycle
	input  cache_pkg::lookup_t           lookup,
	output cache_pkg::way_cmd_t          cmd
);

	import cache_pkg::*;

	apb_state_e                 state;        // Current FSM state
	apb_state_e                 state_nxt;    // Next FSM state
	cache_op_e                  op_q;         // Kind of the transfer in flight
	cache_addr_t                req_addr;     // Address latched in the setup cycle
	logic [DATA_W-1:0]          req_wdata;    // Write word latched in the setup cycle
	logic [STRB_W-1:0]          req_wstrb;    // Byte strobes latched in the setup cycle
	logic [SETS-1:0][WAY_W-1:0] victim;       // Round robin victim of every set
	logic                       accept;       // Setup cycle of a new transfer
	logic                       fill_resolve; // Fill decides its way this cycle
	logic                       fill_alloc;   // Fill misses and takes the victim way
	logic [WAY_W-1:0]           fill_way;     // Way that receives the fill
	logic [WAYS-1:0]            tag_we_q;     // Tag write enables for st_write
	logic [WAYS-1:0]            data_we_q;    // Data write enables for st_write
	logic                       alloc_q;      // Fill clears the rest of the line

	assign accept       = (state == st_idle) && psel;
	assign fill_resolve = (state == st_resolve) && (op_q == op_fill);
	assign fill_alloc   = !lookup.tag_hit_any;
	assign fill_way     = fill_alloc ? victim[req_addr.set] : lookup.tag_hit_way;

	always_comb begin
		state_nxt = state;
		case (state)
			st_idle: begin
				if (accept) begin
					state_nxt = st_lookup; // Access phase starts next cycle
				end
			end
			st_lookup:  state_nxt = st_resolve;
			st_resolve: state_nxt = (op_q == op_fill) ? st_write : st_idle; // Reads end here
			st_write:   state_nxt = st_idle;
			default:    state_nxt = st_idle;
		endcase
	end

	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			state <= st_idle;
			op_q  <= op_lookup;
		end else begin
			state <= state_nxt;
			if (accept) begin
				op_q <= pwrite ? op_fill : op_lookup;
			end
		end
	end

	// Request payload held for the rest of the transfer
	always_ff @(posedge CLK) begin
		if (accept) begin
			req_addr  <= cache_addr_t'(paddr);
			req_wdata <= pwdata;
			req_wstrb <= pstrb;
		end
	end

	// Way choice for fills and the victim rotation
	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			tag_we_q  <= '0;
			data_we_q <= '0;
			alloc_q   <= 1'b0;
			victim    <= '0;
		end else if (fill_resolve) begin
			data_we_q <= WAYS'(1) << fill_way;                         // Hit way or victim
			tag_we_q  <= fill_alloc ? (WAYS'(1) << fill_way) : '0;     // Tag only on a miss
			alloc_q   <= fill_alloc;
			if (fill_alloc) begin
				victim[req_addr.set] <= victim[req_addr.set] + 1'b1; // Wraps after the last way
			end
		end else begin
			tag_we_q  <= '0; // Enables last exactly one cycle
			data_we_q <= '0;
			alloc_q   <= 1'b0;
		end
	end

	always_comb begin
		cmd.rd_en   = (state == st_lookup); // Single read pulse per transfer
		cmd.addr    = req_addr;
		cmd.wdata   = req_wdata;
		cmd.wstrb   = req_wstrb;
		cmd.tag_we  = tag_we_q;
		cmd.data_we = data_we_q;
		cmd.alloc   = alloc_q;
	end

	assign resolve = (state == st_resolve) && (op_q == op_lookup);
	assign pready  = resolve || (state == st_write); // Second access cycle for reads and third for writes

	// At most one way is written per fill
	a_we_onehot: assert property (@(posedge CLK) disable iff (!arst_n)
		$onehot0(cmd.tag_we) && $onehot0(cmd.data_we));

	// The master keeps the address until the transfer completes
	a_paddr_stable: assert property (@(posedge CLK) disable iff (!arst_n)
		(psel && !pready) |=> $stable(paddr));

	// penable is only seen in the access phase after an accepted setup
	a_setup_first: assert property (@(posedge CLK) disable iff (!arst_n)
		accept |-> !penable);

endmodule

// ==== cache_hit_select.sv ====
`timescale 1ns/1ps

module cache_hit_select (
	input  logic                         CLK,
	input  logic                         arst_n,
	input  cache_pkg::way_rsp_t          rsp [cache_pkg::WAYS], // Results of all ways
	input  logic                         rd_valid,              // Read results are due
	output cache_pkg::lookup_t           lookup,
	output logic [cache_pkg::DATA_W-1:0] prdata,
	output logic                         pslverr
);

	import cache_pkg::*;

	logic [WAYS-1:0]  hit_vec; // Ways holding the addressed word
	logic [WAYS-1:0]  tag_vec; // Ways holding the addressed line
	logic [WAY_W-1:0] hit_way; // Encoded index of the word hit
	logic [WAY_W-1:0] tag_way; // Encoded index of the line hit
	logic             any_hit; // Read can be served

	// Gather the way results and encode them
	// Both vectors are one hot at most so the last match is the only match
	always_comb begin
		hit_way = '0;
		tag_way = '0;
		for (int w = 0; w < WAYS; w++) begin
			hit_vec[w] = rsp[w].hit;
			tag_vec[w] = rsp[w].tag_hit;
			if (rsp[w].hit) begin
				hit_way = WAY_W'(w);
			end
			if (rsp[w].tag_hit) begin
				tag_way = WAY_W'(w);
			end
		end
	end

	assign any_hit = |hit_vec;

	// Line ownership goes back to the controller for the fill decision
	assign lookup.tag_hit_any = |tag_vec;
	assign lookup.tag_hit_way = tag_way;

	// Read data and error only in the completion cycle of a read
	assign prdata  = (rd_valid && any_hit) ? rsp[hit_way].rdata : '0; // Zero on a miss
	assign pslverr = rd_valid && !any_hit;                            // A miss is an error

	// A tag lives in one way of a set at most so no two ways can match
	a_hits_onehot: assert property (@(posedge CLK) disable iff (!arst_n)
		$onehot0(hit_vec) && $onehot0(tag_vec));

endmodule

// ==== cache_pkg.sv ====
package cache_pkg;

	// Size of the array and of a word
	localparam int ADDR_W     = 32;                         // Byte address width of the APB bus
	localparam int DATA_W     = 32;                         // One cache word
	localparam int STRB_W     = DATA_W / 8;                 // One strobe per byte lane
	localparam int WAYS       = 4;                          // Ways per set
	localparam int WAY_W      = 2;                          // Index of a way
	localparam int SETS       = 16;                         // Sets in every way
	localparam int SET_W      = 4;                          // Index of a set
	localparam int LINE_WORDS = 4;                          // Words held by one line
	localparam int WORD_W     = 2;                          // Index of a word inside a line
	localparam int TAG_W      = ADDR_W - SET_W - WORD_W - 2; // Upper address bits kept as the tag
	localparam int TAG_STRB_W = (TAG_W + 7) / 8;            // Byte lanes of the tag memory

	// Byte address split into its cache fields
	typedef struct packed {
		logic [TAG_W-1:0]  tag;  // Compared against the stored tag
		logic [SET_W-1:0]  set;  // Selects the line in every way
		logic [WORD_W-1:0] word; // Selects the word in the line
		logic [1:0]        off;  // Byte offset which the word access ignores
	} cache_addr_t;

	// Kind of transfer the controller is serving
	typedef enum logic {
		op_lookup, // APB read
		op_fill    // APB write
	} cache_op_e;

	// Request broadcast from the controller to every way
	typedef struct packed {
		logic              rd_en;   // Reads tag and data memories of all ways
		cache_addr_t       addr;    // Held for the whole transfer
		logic [DATA_W-1:0] wdata;   // Word to merge into the data memory
		logic [STRB_W-1:0] wstrb;   // Byte lanes of wdata that are written
		logic [WAYS-1:0]   tag_we;  // One hot select of the way that takes a new tag
		logic [WAYS-1:0]   data_we; // One hot select of the way that takes the word
		logic              alloc;   // Line is newly taken so only this word stays valid
	} way_cmd_t;

	// Result of one way for the registered lookup
	typedef struct packed {
		logic              hit;     // Tag matches and the addressed word is valid
		logic              tag_hit; // Tag matches and the line holds some valid word
		logic [DATA_W-1:0] rdata;   // Word read from this way
	} way_rsp_t;

	// Summary of the lookup handed back to the controller for fills
	typedef struct packed {
		logic             tag_hit_any; // Some way already owns the line
		logic [WAY_W-1:0] tag_hit_way; // Index of that way
	} lookup_t;

	// Controller FSM
	typedef enum logic [1:0] {
		st_idle,    // Waits for psel
		st_lookup,  // Memories are read
		st_resolve, // Way results are valid
		st_write    // Fill is written and pready is raised
	} apb_state_e;

endpackage

// ==== cache_top.sv ====
`timescale 1ns/1ps

module cache_top (
	input  logic                         CLK,
	input  logic                         arst_n,
	input  logic                         psel,
	input  logic                         penable,
	input  logic                         pwrite,
	input  logic [cache_pkg::ADDR_W-1:0] paddr,
	input  logic [cache_pkg::DATA_W-1:0] pwdata,
	input  logic [cache_pkg::STRB_W-1:0] pstrb,
	output logic                         pready,
	output logic [cache_pkg::DATA_W-1:0] prdata,
	output logic                         pslverr
);

	import cache_pkg::*;

	way_cmd_t cmd;         // Request shared by all ways
	way_rsp_t rsp [WAYS];  // One result per way
	lookup_t  lookup;      // Line ownership for fills
	logic     resolve;     // Read completion cycle

	// APB slave FSM and victim pointers
	cache_apb_ctrl i_ctrl (
		.CLK     (CLK),
		.arst_n  (arst_n),
		.psel    (psel),
		.penable (penable),
		.pwrite  (pwrite),
		.paddr   (paddr),
		.pwdata  (pwdata),
		.pstrb   (pstrb),
		.pready  (pready),
		.resolve (resolve),
		.lookup  (lookup),
		.cmd     (cmd)
	);

	// Identical ways that each pick their own write enable bit
	generate
		for (genvar w = 0; w < WAYS; w++) begin : g_way
			cache_way i_way (
				.CLK     (CLK),
				.arst_n  (arst_n),
				.way_idx (WAY_W'(w)),
				.cmd     (cmd),
				.rsp     (rsp[w])
			);
		end
	endgenerate

	// Hit detection and APB read response
	cache_hit_select i_sel (
		.CLK      (CLK),
		.arst_n   (arst_n),
		.rsp      (rsp),
		.rd_valid (resolve),
		.lookup   (lookup),
		.prdata   (prdata),
		.pslverr  (pslverr)
	);

endmodule

// ==== cache_way.sv ====
`timescale 1ns/1ps

module cache_way (
	input  logic                        CLK,
	input  logic                        arst_n,
	input  logic [cache_pkg::WAY_W-1:0] way_idx, // Position of this way in the array
	input  cache_pkg::way_cmd_t         cmd,
	output cache_pkg::way_rsp_t         rsp
);

	import cache_pkg::*;

	logic [SETS-1:0][LINE_WORDS-1:0] valid;     // One valid flag per word of every line
	logic [TAG_W-1:0]                tag_q;     // Tag read from the tag memory
	logic [DATA_W-1:0]               data_q;    // Word read from the data memory
	logic [TAG_W-1:0]                rd_tag;    // Request tag captured with the read
	logic [SET_W-1:0]                rd_set;    // Set of the outstanding read
	logic [WORD_W-1:0]               rd_word;   // Word of the outstanding read
	logic [SET_W+WORD_W-1:0]         line_addr; // Word address inside the data memory
	logic                            tag_we;    // Tag write for this way
	logic                            data_we;   // Data write for this way
	logic                            tag_eq;    // Stored tag equals the request tag

	assign tag_we    = cmd.tag_we[way_idx];          // Each way picks its own bit
	assign data_we   = cmd.data_we[way_idx];
	assign line_addr = {cmd.addr.set, cmd.addr.word}; // Lines are laid out word by word

	// Tag memory with one entry per set
	gen_sram #(
		.DW (TAG_W),
		.AW (SET_W)
	) i_tag_ram (
		.CLK        (CLK),
		.en_w       (tag_we),
		.addr_w     (cmd.addr.set),
		.data_w     (cmd.addr.tag),
		.data_wstrb ({TAG_STRB_W{1'b1}}), // A tag is always written whole
		.en_r       (cmd.rd_en),
		.addr_r     (cmd.addr.set),
		.data_r     (tag_q)
	);

	// Data memory with one entry per word of every line
	gen_sram #(
		.DW (DATA_W),
		.AW (SET_W + WORD_W)
	) i_data_ram (
		.CLK        (CLK),
		.en_w       (data_we),
		.addr_w     (line_addr),
		.data_w     (cmd.wdata),
		.data_wstrb (cmd.wstrb), // APB strobes go straight to the byte lanes
		.en_r       (cmd.rd_en),
		.addr_r     (line_addr),
		.data_r     (data_q)
	);

	// Request fields lined up with the registered memory outputs
	always_ff @(posedge CLK) begin
		if (cmd.rd_en) begin
			rd_tag  <= cmd.addr.tag;
			rd_set  <= cmd.addr.set;
			rd_word <= cmd.addr.word;
		end
	end

	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			valid <= '0; // Every line starts empty
		end else if (data_we) begin
			if (cmd.alloc) begin
				valid[cmd.addr.set] <= LINE_WORDS'(1) << cmd.addr.word; // Old line is dropped
			end else begin
				valid[cmd.addr.set][cmd.addr.word] <= 1'b1; // Line grows by one word
			end
		end
	end

	assign tag_eq      = (tag_q == rd_tag);
	assign rsp.hit     = tag_eq && valid[rd_set][rd_word];
	assign rsp.tag_hit = tag_eq && (|valid[rd_set]);
	assign rsp.rdata   = data_q;

	// A write only follows a lookup that went through st_resolve
	a_write_after_lookup: assert property (@(posedge CLK) disable iff (!arst_n)
		(tag_we || data_we) |-> !cmd.rd_en && $past(cmd.rd_en, 2));

endmodule

// ==== gen_sram.sv ====
`timescale 1ns/1ps

module gen_sram #(
	parameter int DW = 32, // Bits per entry
	parameter int AW = 4   // Address bits so the array holds 2**AW entries
) (
	input  logic                CLK,
	input  logic                en_w,       // Write strobe
	input  logic [AW-1:0]       addr_w,     // Write address
	input  logic [DW-1:0]       data_w,     // Write data
	input  logic [(DW+7)/8-1:0] data_wstrb, // One enable per byte of data_w
	input  logic                en_r,       // Read strobe
	input  logic [AW-1:0]       addr_r,     // Read address
	output logic [DW-1:0]       data_r      // Registered read data
);

	logic [DW-1:0] mem [2**AW]; // Storage array

	// Byte masked write
	// Every bit follows the strobe of the byte it lives in so a width that is
	// not a multiple of eight still writes its top partial byte
	always_ff @(posedge CLK) begin
		if (en_w) begin
			for (int i = 0; i < DW; i++) begin
				if (data_wstrb[i/8]) begin
					mem[addr_w][i] <= data_w[i]; // Unstrobed bits keep their old value
				end
			end
		end
	end

	// Read port with one cycle of latency
	always_ff @(posedge CLK) begin
		if (en_r) begin
			data_r <= mem[addr_r]; // Output holds the last read while en_r is low
		end
	end

	// A read and a write to one address in one cycle return the old entry
	// The cache never does this because it reads and writes in different states

endmodule

// ==== list.f ====
cache_pkg.sv
gen_sram.sv
cache_way.sv
cache_apb_ctrl.sv
cache_hit_select.sv
cache_top.sv
tb_cache.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the cache testbench with Verilator and runs it with all output in sim.log
# A failed build or run also leaves the fail message in the log

rm -rf obj_dir sim.log
verilator --binary --assert --top-module tb_cache -f list.f -o tb_cache_sim > sim.log 2>&1 \
	&& ./obj_dir/tb_cache_sim >> sim.log 2>&1 \
	|| echo "Errors found" >> sim.log

if grep -q "Errors found" sim.log; then
	echo "Simulation failed, see sim.log"
	exit 1
fi
echo "Simulation passed"
exit 0

// ==== tb_cache.sv ====
`timescale 1ns/1ps

module tb_cache;

	import cache_pkg::*;

	localparam int RAND_OPS       = 300;         // Transfers in the random mix
	localparam int TIMEOUT_CYCLES = 2 * 400 * 5; // About twice 400 transfers of up to 5 cycles

	logic              clk;
	logic              arst_n;
	logic              psel;
	logic              penable;
	logic              pwrite;
	logic [ADDR_W-1:0] paddr;
	logic [DATA_W-1:0] pwdata;
	logic [STRB_W-1:0] pstrb;
	logic              pready;
	logic [DATA_W-1:0] prdata;
	logic              pslverr;

	logic [TAG_W-1:0]      m_tag    [WAYS][SETS];             // Tag owned by each line
	logic [LINE_WORDS-1:0] m_valid  [WAYS][SETS];             // Valid words of each line
	logic [DATA_W-1:0]     m_data   [WAYS][SETS][LINE_WORDS]; // Word contents of each line
	logic [WAY_W-1:0]      m_victim [SETS];                   // Next way to replace in a set

	logic [DATA_W-1:0] exp_prdata;  // Read word the model predicts
	logic              exp_pslverr; // Miss predicted by the model
	logic              exp_pready;  // pready is due in this cycle
	logic [2:0]        lat;         // Access cycles since the setup cycle
	int                cycle_count; // Clock cycles since time zero
	int                seed;        // Seed of $random

	cache_top i_dut (
		.CLK     (clk),
		.arst_n  (arst_n),
		.psel    (psel),
		.penable (penable),
		.pwrite  (pwrite),
		.paddr   (paddr),
		.pwdata  (pwdata),
		.pstrb   (pstrb),
		.pready  (pready),
		.prdata  (prdata),
		.pslverr (pslverr)
	);

	always #5 clk = ~clk; // 10 ns period

	// Reads complete in the second access cycle and writes in the third
	always @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			lat <= '0;
		end else if (psel && !penable) begin
			lat <= 3'd1; // First access cycle follows the setup cycle
		end else if (psel) begin
			lat <= lat + 3'd1;
		end
	end

	assign exp_pready = penable && (lat == (pwrite ? 3'd3 : 3'd2));

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count == TIMEOUT_CYCLES) begin
			$display("Timeout after %0d cycles before the tests completed", cycle_count);
			fail_run();
		end
	end

	task automatic fail_run();
		$display("Errors found");
		$fatal(1);
	endtask

	a_prdata: assert property (@(posedge clk) disable iff (!arst_n)
		(pready && !pwrite) |-> prdata == exp_prdata)
	else begin
		$display("MISMATCH time=%0t signal=prdata expected=%h actual=%h",
			$time, $sampled(exp_prdata), $sampled(prdata));
		fail_run();
	end

	// Writes never report an error
	a_pslverr: assert property (@(posedge clk) disable iff (!arst_n)
		pready |-> pslverr == (exp_pslverr && !pwrite))
	else begin
		$display("MISMATCH time=%0t signal=pslverr expected=%b actual=%b",
			$time, $sampled(exp_pslverr && !pwrite), $sampled(pslverr));
		fail_run();
	end

	// Covers both a late and an early pready
	a_pready: assert property (@(posedge clk) disable iff (!arst_n)
		psel |-> pready == exp_pready)
	else begin
		$display("MISMATCH time=%0t signal=pready expected=%b actual=%b",
			$time, $sampled(exp_pready), $sampled(pready));
		fail_run();
	end

	function automatic logic [ADDR_W-1:0] make_addr(input logic [TAG_W-1:0] tag,
		input logic [SET_W-1:0] set_idx, input logic [WORD_W-1:0] word);
		return {tag, set_idx, word, 2'b00}; // Word aligned byte address
	endfunction

	// Way whose line holds the tag or -1 when the line is absent
	function automatic int find_line(input logic [TAG_W-1:0] tag, input logic [SET_W-1:0] set_idx);
		int way;
		way = -1;
		for (int w = 0; w < WAYS; w++) begin
			if (m_valid[w][set_idx] != '0 && m_tag[w][set_idx] == tag) begin
				way = w;
			end
		end
		return way;
	endfunction

	function automatic logic [DATA_W-1:0] merge_bytes(input logic [DATA_W-1:0] old_word,
		input logic [DATA_W-1:0] new_word, input logic [STRB_W-1:0] strb);
		logic [DATA_W-1:0] word;
		word = old_word;
		for (int b = 0; b < STRB_W; b++) begin
			if (strb[b]) begin
				word[8*b +: 8] = new_word[8*b +: 8]; // Unstrobed bytes stay as they were
			end
		end
		return word;
	endfunction

	task automatic predict_read(input logic [ADDR_W-1:0] addr);
		cache_addr_t a;
		int          way;
		a   = cache_addr_t'(addr);
		way = find_line(a.tag, a.set);
		exp_prdata  = '0;   // A miss returns zero
		exp_pslverr = 1'b1;
		if (way >= 0) begin
			if (m_valid[way][a.set][a.word]) begin
				exp_prdata  = m_data[way][a.set][a.word];
				exp_pslverr = 1'b0;
			end
		end
	endtask

	task automatic update_model(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
		input logic [STRB_W-1:0] strb);
		cache_addr_t a;
		int          way;
		a   = cache_addr_t'(addr);
		way = find_line(a.tag, a.set);
		if (way < 0) begin
			way = int'(m_victim[a.set]);                    // Miss takes the victim way
			m_victim[a.set]     = m_victim[a.set] + WAY_W'(1); // Round robin over the ways
			m_tag[way][a.set]   = a.tag;
			m_valid[way][a.set] = '0;                       // Old line is dropped
		end
		m_valid[way][a.set][a.word] = 1'b1;
		m_data[way][a.set][a.word]  = merge_bytes(m_data[way][a.set][a.word], data, strb);
	endtask

	// Waits for pready and returns 1 ns after the closing edge
	task automatic finish_transfer();
		do begin
			@(negedge clk); // pready has settled half a cycle after the edge
		end while (!pready);
		@(posedge clk);
		#1;
		psel    = 1'b0;
		penable = 1'b0;
	endtask

	task automatic apb_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
		input logic [STRB_W-1:0] strb);
		psel    = 1'b1; // Setup cycle
		penable = 1'b0;
		pwrite  = 1'b1;
		paddr   = addr;
		pwdata  = data;
		pstrb   = strb;
		@(posedge clk);
		#1 penable = 1'b1;
		finish_transfer();
		update_model(addr, data, strb);
	endtask

	task automatic apb_read(input logic [ADDR_W-1:0] addr);
		predict_read(addr);
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = 1'b0;
		paddr   = addr;
		@(posedge clk);
		#1 penable = 1'b1;
		finish_transfer();
	endtask

	initial begin
		int                t;
		int                way;
		logic [31:0]       rnd;
		logic [TAG_W-1:0]  tag_v;
		logic [SET_W-1:0]  set_v;
		logic [ADDR_W-1:0] addr;
		logic [DATA_W-1:0] data_v;
		clk         = 1'b0;
		arst_n      = 1'b0;
		psel        = 1'b0;
		penable     = 1'b0;
		pwrite      = 1'b0;
		paddr       = '0;
		pwdata      = '0;
		pstrb       = '0;
		exp_prdata  = '0;
		exp_pslverr = 1'b1;
		cycle_count = 0;
		seed        = 32'h0a98_04b0;
		foreach (m_valid[w, s]) begin
			m_valid[w][s] = '0; // Matches the cleared valid flops
		end
		foreach (m_victim[s]) begin
			m_victim[s] = '0;
		end
		repeat (8) @(posedge clk);
		#1 arst_n = 1'b1;
		@(posedge clk);
		#1;
		for (t = 0; t < 4; t++) begin
			rnd = $random(seed);
			apb_read(rnd); // Empty array so every read misses
		end
		apb_write(make_addr(24'h00_0011, 4'd1, 2'd2), 32'hcafe_0123, 4'hf);
		apb_read(make_addr(24'h00_0011, 4'd1, 2'd2));
		apb_write(make_addr(24'h00_0011, 4'd1, 2'd2), 32'h5a5a_a5a5, 4'b0101); // Bytes 0 and 2
		apb_read(make_addr(24'h00_0011, 4'd1, 2'd2));
		for (t = 0; t < 5; t++) begin
			apb_write(make_addr(TAG_W'(32'h100 + t), 4'd5, 2'd0), 32'h1000_0000 + t, 4'hf);
		end
		for (t = 0; t < 5; t++) begin
			apb_read(make_addr(TAG_W'(32'h100 + t), 4'd5, 2'd0)); // The first tag was evicted
		end
		apb_write(make_addr(24'h00_0200, 4'd9, 2'd0), 32'h0bad_f00d, 4'hf);
		apb_read(make_addr(24'h00_0200, 4'd9, 2'd1)); // Line present but word 1 is not
		apb_write(make_addr(24'h00_0200, 4'd9, 2'd1), 32'h600d_cafe, 4'hf);
		apb_read(make_addr(24'h00_0200, 4'd9, 2'd1));
		apb_read(make_addr(24'h00_0200, 4'd9, 2'd0));
		for (t = 0; t < RAND_OPS; t++) begin
			rnd    = $random(seed);
			data_v = $random(seed);
			tag_v  = TAG_W'(32'h0000_0a50 + int'(rnd[15:8]) % 6); // Six tags compete for 4 ways
			set_v  = SET_W'(3 + 5 * (int'(rnd[7:0]) % 3));       // Three sets of the mix
			addr   = make_addr(tag_v, set_v, rnd[17:16]);
			if (rnd[18]) begin
				way = find_line(tag_v, set_v);
				if (way >= 0 && m_valid[way][set_v][rnd[17:16]]) begin
					apb_write(addr, data_v, rnd[23:20]); // Partial strobes only on a known word
				end else begin
					apb_write(addr, data_v, 4'hf);
				end
			end else begin
				apb_read(addr);
			end
		end
		repeat (3) @(posedge clk);
		$display("No errors");
		$finish;
	end

endmodule
